// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_datapath
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
verilog/cpu_types_pkg.sv
verilog/pipe_reg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/forward_unit.sv
verilog/datapath.sv
tests/tb_datapath.sv

// File: tests/tb_datapath.sv
// testbench for the pipelined core
// lfsr program generator, memory models, isa model, store stream and dump checks
`timescale 1ns/1ps

module tb_datapath;
  import cpu_types_pkg::*;

  localparam word_t PC_INIT   = 32'h0;
  localparam int    SEED      = 74063;
  localparam int    N_INSTR   = 200;
  localparam int    DUMP_BASE = 256;
  localparam int    POST_HALT = 10;

  // random pick tables
  localparam funct_t  R_OPS [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                     FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL};
  localparam opcode_t I_OPS [6]  = '{ADDIU, ANDI, ORI, XORI, LUI, SLTI};

  logic  CLK;
  logic  rst_n;
  word_t imemaddr;
  logic  imemREN;
  word_t imemload;
  logic  ihit;
  word_t dmemaddr;
  word_t dmemstore;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemload;
  logic  halt;

  // program, data memory and isa model state
  word_t       imem [512];
  word_t       dmem [128];
  word_t       mdl_mem [128];
  word_t       mdl_regs [32];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       got_addr [$];
  word_t       got_data [$];
  word_t       ioff;
  int          prog_len;
  logic        prog_ready;
  logic        halt_seen;
  int          late_stores = 0;
  int          check_count = 0;
  int          error_count = 0;
  logic [15:0] lfsr;

  datapath #(.PC_INIT(PC_INIT)) datapath_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .imemaddr  (imemaddr),
    .imemREN   (imemREN),
    .imemload  (imemload),
    .ihit      (ihit),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemload  (dmemload),
    .halt      (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // registers 1 to 15 with zero folded onto 15
  function automatic regbits_t pick_reg();
    word_t v;
    v = rand_bits(4);
    return (v[3:0] == 4'd0) ? 5'd15 : {1'b0, v[3:0]};
  endfunction

  function automatic word_t fill_word(int idx);
    word_t a;
    a = word_t'(idx);
    return (a * 32'h9e37_79b9) ^ {~a[15:0], a[15:0]};
  endfunction

  function automatic word_t r_word(regbits_t rs, regbits_t rt, regbits_t rd,
                                   regbits_t sh, funct_t fn);
    return {RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t i_word(opcode_t op, regbits_t rs, regbits_t rt,
                                   logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // isa semantics of the r-type functions
  function automatic word_t reg_result(funct_t fn, word_t a, word_t b, regbits_t sh);
    word_t r;
    case (fn)
      FN_ADDU: r = a + b;
      FN_SUBU: r = a - b;
      FN_AND:  r = a & b;
      FN_OR:   r = a | b;
      FN_XOR:  r = a ^ b;
      FN_NOR:  r = ~(a | b);
      FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      FN_SLL:  r = b << sh;
      default: r = b >> sh;
    endcase
    return r;
  endfunction

  // isa semantics of the immediate forms
  function automatic word_t imm_result(opcode_t op, word_t a, logic [15:0] imm);
    word_t s;
    word_t r;
    s = {{16{imm[15]}}, imm};
    case (op)
      ADDIU:   r = a + s;
      SLTI:    r = ($signed(a) < $signed(s)) ? 32'd1 : 32'd0;
      ANDI:    r = a & {16'd0, imm};
      ORI:     r = a | {16'd0, imm};
      XORI:    r = a ^ {16'd0, imm};
      default: r = {imm, 16'd0};
    endcase
    return r;
  endfunction

  task automatic set_reg(regbits_t r, word_t v);
    // r0 stays zero
    if (r != 5'd0) begin
      mdl_regs[r] = v;
    end
  endtask

  task automatic emit(word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // one random slot run through the model as it is emitted
  task automatic gen_one();
    word_t       sel;
    word_t       w;
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    rd;
    regbits_t    sh;
    logic [15:0] imm;
    logic [15:0] off;
    funct_t      fn;
    opcode_t     op;
    logic        shift;
    sel = rand_bits(5);
    rs  = pick_reg();
    rt  = pick_reg();
    rd  = pick_reg();
    w   = rand_bits(5);
    sh  = w[4:0];
    w   = rand_bits(16);
    imm = w[15:0];
    w   = rand_bits(6);
    // word-aligned offset inside the 64-word window with base r0
    off = {8'd0, w[5:0], 2'b00};
    if (sel < 32'd10) begin
      fn    = R_OPS[sel[3:0]];
      shift = (fn == FN_SLL) || (fn == FN_SRL);
      emit(r_word(shift ? 5'd0 : rs, rt, rd, shift ? sh : 5'd0, fn));
      set_reg(rd, reg_result(fn, mdl_regs[rs], mdl_regs[rt], sh));
    end else if (sel < 32'd16) begin
      op = I_OPS[int'(sel) - 10];
      emit(i_word(op, (op == LUI) ? 5'd0 : rs, rt, imm));
      set_reg(rt, imm_result(op, mdl_regs[rs], imm));
    end else if (sel < 32'd21) begin
      emit(i_word(LW, 5'd0, rt, off));
      set_reg(rt, mdl_mem[w[5:0]]);
      // gap after the load with its result dropped into r0
      emit(i_word(ORI, 5'd0, 5'd0, imm));
    end else begin
      emit(i_word(SW, 5'd0, rt, off));
      mdl_mem[w[5:0]] = mdl_regs[rt];
      exp_addr.push_back({16'd0, off});
      exp_data.push_back(mdl_regs[rt]);
    end
  endtask

  task automatic build_program();
    lfsr     = SEED[15:0];
    prog_len = 0;
    for (int i = 0; i < 512; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 128; i++) begin
      mdl_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      mdl_regs[i] = '0;
    end
    for (int n = 0; n < N_INSTR; n++) begin
      gen_one();
    end
    // dump r1..r31 above the window and then stop
    for (int i = 1; i < 32; i++) begin
      emit(i_word(SW, 5'd0, regbits_t'(i), 16'(DUMP_BASE + 4 * i)));
      exp_addr.push_back(word_t'(DUMP_BASE + 4 * i));
      exp_data.push_back(mdl_regs[i]);
    end
    emit(32'hffff_ffff);
  endtask

  task automatic check_value(string name, word_t expected, word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(string name, int mark);
    $display("test %s: %s", name, (error_count == mark) ? "ok" : "errors");
  endtask

  // instruction memory answers at the current pc
  assign ioff     = imemaddr - PC_INIT;
  assign imemload = imem[ioff[10:2]];

  // data memory returns read data only while the read strobe is up
  assign dmemload = dmemREN ? dmem[dmemaddr[8:2]] : '0;

  initial begin
    for (int i = 0; i < 128; i++) begin
      dmem[i] <= fill_word(i);
    end
  end

  always @(posedge CLK) begin
    if (dmemWEN) begin
      dmem[dmemaddr[8:2]] <= dmemstore;
      if (halt_seen) begin
        late_stores++;
      end else begin
        got_addr.push_back(dmemaddr);
        got_data.push_back(dmemstore);
      end
    end
  end

  initial begin
    int    mark;
    word_t draw;
    word_t exp_pc;
    word_t fetch_end;
    rst_n      = 1'b0;
    ihit       = 1'b0;
    halt_seen  = 1'b0;
    prog_ready = 1'b0;
    build_program();
    prog_ready = 1'b1;
    // pc parks two words past HALT once HALT leaves ID
    fetch_end  = PC_INIT + word_t'(4 * (prog_len + 1));
    exp_pc     = PC_INIT;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    // ihit still low so nothing is accepted yet
    mark = error_count;
    check_value("imemaddr", PC_INIT, imemaddr);
    check_value("imemREN", 32'd1, {31'd0, imemREN});
    check_value("dmemREN", 32'd0, {31'd0, dmemREN});
    check_value("dmemWEN", 32'd0, {31'd0, dmemWEN});
    check_value("halt", 32'd0, {31'd0, halt});
    report_test("reset state", mark);

    // ihit low about one cycle in four
    mark = error_count;
    while (!halt_seen) begin
      draw = rand_bits(2);
      ihit = (draw[1:0] != 2'b00);
      if (ihit && (exp_pc != fetch_end)) begin
        exp_pc = exp_pc + 32'd4;
      end
      @(negedge CLK);
      check_value("imemaddr", exp_pc, imemaddr);
      check_value("imemREN", {31'd0, exp_pc != fetch_end}, {31'd0, imemREN});
      if (halt) begin
        halt_seen = 1'b1;
      end
    end
    report_test("fetch sequence", mark);

    // keep clocking past halt
    mark = error_count;
    repeat (POST_HALT) begin
      draw = rand_bits(2);
      ihit = (draw[1:0] != 2'b00);
      @(negedge CLK);
      check_value("halt", 32'd1, {31'd0, halt});
      check_value("imemREN", 32'd0, {31'd0, imemREN});
    end
    if (late_stores != 0) begin
      error_count++;
      $display("%0d store writes seen after halt rose", late_stores);
    end
    report_test("halt", mark);

    mark = error_count;
    check_value("store count", word_t'(exp_addr.size()), word_t'(got_addr.size()));
    report_test("store count", mark);

    // in-order compare of the store stream
    mark = error_count;
    for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check_value("dmemaddr", exp_addr[i], got_addr[i]);
      check_value("dmemstore", exp_data[i], got_data[i]);
    end
    report_test("store stream", mark);

    mark = error_count;
    for (int i = 1; i < 32; i++) begin
      check_value($sformatf("dump r%0d", i), mdl_regs[i], dmem[DUMP_BASE / 4 + i]);
    end
    report_test("register dump", mark);

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // limit scales with program length
  initial begin
    int limit;
    wait (prog_ready);
    limit = prog_len * 20 + 200;
    repeat (limit) @(posedge CLK);
    $display("timeout: halt did not rise within %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog/alu.sv
// combinational alu
// add/sub, logic, signed and unsigned compare, shifts, lui
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  input  cpu_types_pkg::aluop_t alu_op,
  output cpu_types_pkg::word_t  result
);
  import cpu_types_pkg::*;

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = port_a + port_b;
      ALU_SUB:  result = port_a - port_b;
      ALU_AND:  result = port_a & port_b;
      ALU_OR:   result = port_a | port_b;
      ALU_XOR:  result = port_a ^ port_b;
      ALU_NOR:  result = ~(port_a | port_b);
      // compares give 0 or 1
      ALU_SLT:  result = {31'd0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: result = {31'd0, port_a < port_b};
      // shift amount rides on port a, value on port b
      ALU_SLL:  result = port_b << port_a[4:0];
      ALU_SRL:  result = port_b >> port_a[4:0];
      // upper immediate, low half cleared
      ALU_LUI:  result = {port_b[15:0], 16'd0};
      default:  result = '0;
    endcase
  end

endmodule

// File: verilog/control_unit.sv
// instruction decoder for the ID stage
// maps opcode and funct onto alu op, operand selects and strobes
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::word_t  instr,
  output cpu_types_pkg::aluop_t alu_op,
  output logic                  alu_src_imm,
  output logic                  shift_src,
  output logic                  reg_dest_rt,
  output logic                  extend_sign,
  output logic                  dren,
  output logic                  dwen,
  output logic                  wen,
  output logic                  halt
);
  import cpu_types_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // unknown encodings fall through as a no-op
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    shift_src   = 1'b0;
    reg_dest_rt = 1'b0;
    extend_sign = 1'b0;
    dren        = 1'b0;
    dwen        = 1'b0;
    wen         = 1'b0;
    halt        = 1'b0;

    case (opcode)
      RTYPE: begin
        // rd destination, both operands from registers
        wen = 1'b1;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          FN_SLL: begin
            alu_op    = ALU_SLL;
            shift_src = 1'b1;
          end
          FN_SRL: begin
            alu_op    = ALU_SRL;
            shift_src = 1'b1;
          end
          default: wen = 1'b0;
        endcase
      end
      ADDIU, SLTI, LW, SW: begin
        // sign-extended immediate forms
        alu_op      = (opcode == SLTI) ? ALU_SLT : ALU_ADD;
        alu_src_imm = 1'b1;
        reg_dest_rt = 1'b1;
        extend_sign = 1'b1;
        dren        = (opcode == LW);
        dwen        = (opcode == SW);
        wen         = (opcode != SW);
      end
      ANDI, ORI, XORI, LUI: begin
        // zero-extended immediate forms
        alu_src_imm = 1'b1;
        reg_dest_rt = 1'b1;
        wen         = 1'b1;
        case (opcode)
          ANDI:    alu_op = ALU_AND;
          ORI:     alu_op = ALU_OR;
          XORI:    alu_op = ALU_XOR;
          default: alu_op = ALU_LUI;
        endcase
      end
      HALT: halt = 1'b1;
      default: halt = 1'b0;
    endcase
  end

endmodule

// File: verilog/cpu_types_pkg.sv
// shared types for the pipelined core
// word and register index types, isa encodings, alu ops, stage payloads
package cpu_types_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_ADDU = 6'b100001,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_t;

  // alu operations, ALU_ADD is also the bubble value
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } aluop_t;

  // operand source selects from the forward unit
  localparam logic [1:0] FWD_IDEX  = 2'b00;
  localparam logic [1:0] FWD_EXMEM = 2'b01;
  localparam logic [1:0] FWD_MEMWB = 2'b10;

  // fetched word and the pc it came from
  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  // decoded instruction with register operands
  typedef struct packed {
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t shamt;
    regbits_t rs;
    regbits_t rt;
    regbits_t dest;
    aluop_t   alu_op;
    logic     alu_src_imm;
    logic     shift_src;
    logic     dren;
    logic     dwen;
    logic     wen;
    logic     halt;
  } id_ex_t;

  // alu result doubles as the data address
  typedef struct packed {
    word_t    result;
    word_t    store_data;
    regbits_t dest;
    logic     dren;
    logic     dwen;
    logic     wen;
    logic     halt;
  } ex_mem_t;

  // value headed for the register file
  typedef struct packed {
    word_t    wdata;
    regbits_t dest;
    logic     wen;
    logic     halt;
  } mem_wb_t;

endpackage

// File: verilog/datapath.sv
// five-stage pipelined core top level
// pc, extender, operand and writeback muxes, memory glue, halt logic
`timescale 1ns/1ps

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  // instruction port
  output cpu_types_pkg::word_t imemaddr,
  output logic                 imemREN,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 ihit,
  // data port, answers in the same cycle
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 halt
);
  import cpu_types_pkg::*;

  // fetch state
  word_t pc;
  logic  pc_en;
  logic  fetch_stop;
  logic  halt_q;

  // stage payloads
  if_id_t  if_id_d;
  if_id_t  if_id_q;
  id_ex_t  id_ex_d;
  id_ex_t  id_ex_q;
  ex_mem_t ex_mem_d;
  ex_mem_t ex_mem_q;
  mem_wb_t mem_wb_d;
  mem_wb_t mem_wb_q;

  // per-stage bubble insertion
  logic flush_if_id;
  logic flush_id_ex;
  logic flush_ex_mem;
  logic flush_mem_wb;

  // decode outputs
  aluop_t cu_alu_op;
  logic   cu_alu_src_imm;
  logic   cu_shift_src;
  logic   cu_reg_dest_rt;
  logic   cu_extend_sign;
  logic   cu_dren;
  logic   cu_dwen;
  logic   cu_wen;
  logic   cu_halt;

  // ID stage fields and operands
  regbits_t id_rs;
  regbits_t id_rt;
  regbits_t id_rd;
  word_t    rf_rdat1;
  word_t    rf_rdat2;
  word_t    imm_ext;
  logic     rf_wen;

  // EX stage operands
  logic [1:0] fwd_a;
  logic [1:0] fwd_b;
  word_t      fwd_rs_val;
  word_t      fwd_rt_val;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;

  // pc counts up while fetching, no branch targets
  assign pc_en = ihit & ~fetch_stop;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= PC_INIT;
    end else if (pc_en) begin
      pc <= pc + 32'd4;
    end
  end

  // fetch stops once HALT moves into ID/EX
  // halt output holds after HALT leaves MEM/WB
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      fetch_stop <= 1'b0;
      halt_q     <= 1'b0;
    end else begin
      if (ihit && cu_halt) begin
        fetch_stop <= 1'b1;
      end
      if (mem_wb_q.halt) begin
        halt_q <= 1'b1;
      end
    end
  end

  assign imemaddr = pc;
  assign imemREN  = ~fetch_stop;
  assign halt     = halt_q | mem_wb_q.halt;

  // drain behind HALT, each stage flushes once HALT has passed it
  assign flush_if_id  = cu_halt | fetch_stop;
  assign flush_id_ex  = fetch_stop;
  assign flush_ex_mem = fetch_stop & ~id_ex_q.halt;
  assign flush_mem_wb = fetch_stop & ~id_ex_q.halt & ~ex_mem_q.halt;

  // IF
  assign if_id_d.instr = imemload;
  assign if_id_d.pc    = pc;

  pipe_reg #(.payload_t(if_id_t)) if_id_inst (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .enable (ihit),
    .flush  (flush_if_id),
    .d      (if_id_d),
    .q      (if_id_q)
  );

  // ID
  assign id_rs = if_id_q.instr[25:21];
  assign id_rt = if_id_q.instr[20:16];
  assign id_rd = if_id_q.instr[15:11];

  control_unit control_unit_inst (
    .instr       (if_id_q.instr),
    .alu_op      (cu_alu_op),
    .alu_src_imm (cu_alu_src_imm),
    .shift_src   (cu_shift_src),
    .reg_dest_rt (cu_reg_dest_rt),
    .extend_sign (cu_extend_sign),
    .dren        (cu_dren),
    .dwen        (cu_dwen),
    .wen         (cu_wen),
    .halt        (cu_halt)
  );

  // writes come from MEM/WB, frozen with the rest of the pipe
  assign rf_wen = mem_wb_q.wen & ihit;

  register_file register_file_inst (
    .CLK   (CLK),
    .rst_n (rst_n),
    .wen   (rf_wen),
    .wsel  (mem_wb_q.dest),
    .wdat  (mem_wb_q.wdata),
    .rsel1 (id_rs),
    .rsel2 (id_rt),
    .rdat1 (rf_rdat1),
    .rdat2 (rf_rdat2)
  );

  // sign or zero extension of imm16
  assign imm_ext = cu_extend_sign ? {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]}
                                  : {16'd0, if_id_q.instr[15:0]};

  always_comb begin
    id_ex_d.rdat1       = rf_rdat1;
    id_ex_d.rdat2       = rf_rdat2;
    id_ex_d.imm         = imm_ext;
    id_ex_d.shamt       = if_id_q.instr[10:6];
    id_ex_d.rs          = id_rs;
    id_ex_d.rt          = id_rt;
    // writeback destination, rt for i-type
    id_ex_d.dest        = cu_reg_dest_rt ? id_rt : id_rd;
    id_ex_d.alu_op      = cu_alu_op;
    id_ex_d.alu_src_imm = cu_alu_src_imm;
    id_ex_d.shift_src   = cu_shift_src;
    id_ex_d.dren        = cu_dren;
    id_ex_d.dwen        = cu_dwen;
    id_ex_d.wen         = cu_wen;
    id_ex_d.halt        = cu_halt;
  end

  pipe_reg #(.payload_t(id_ex_t)) id_ex_inst (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .enable (ihit),
    .flush  (flush_id_ex),
    .d      (id_ex_d),
    .q      (id_ex_q)
  );

  // EX
  forward_unit forward_unit_inst (
    .rs         (id_ex_q.rs),
    .rt         (id_ex_q.rt),
    .exmem_dest (ex_mem_q.dest),
    .memwb_dest (mem_wb_q.dest),
    .exmem_wen  (ex_mem_q.wen),
    .memwb_wen  (mem_wb_q.wen),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  always_comb begin
    case (fwd_a)
      FWD_EXMEM: fwd_rs_val = ex_mem_q.result;
      FWD_MEMWB: fwd_rs_val = mem_wb_q.wdata;
      default:   fwd_rs_val = id_ex_q.rdat1;
    endcase
    case (fwd_b)
      FWD_EXMEM: fwd_rt_val = ex_mem_q.result;
      FWD_MEMWB: fwd_rt_val = mem_wb_q.wdata;
      default:   fwd_rt_val = id_ex_q.rdat2;
    endcase
  end

  // shamt replaces rs for shifts, imm replaces rt for i-type
  assign alu_a = id_ex_q.shift_src ? {27'd0, id_ex_q.shamt} : fwd_rs_val;
  assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : fwd_rt_val;

  alu alu_inst (
    .port_a (alu_a),
    .port_b (alu_b),
    .alu_op (id_ex_q.alu_op),
    .result (alu_result)
  );

  always_comb begin
    ex_mem_d.result     = alu_result;
    // store data takes the forwarded rt value
    ex_mem_d.store_data = fwd_rt_val;
    ex_mem_d.dest       = id_ex_q.dest;
    ex_mem_d.dren       = id_ex_q.dren;
    ex_mem_d.dwen       = id_ex_q.dwen;
    ex_mem_d.wen        = id_ex_q.wen;
    ex_mem_d.halt       = id_ex_q.halt;
  end

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_inst (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .enable (ihit),
    .flush  (flush_ex_mem),
    .d      (ex_mem_d),
    .q      (ex_mem_q)
  );

  // MEM
  // strobes only on enabled cycles, one write per store
  assign dmemaddr  = ex_mem_q.result;
  assign dmemstore = ex_mem_q.store_data;
  assign dmemREN   = ex_mem_q.dren & ihit;
  assign dmemWEN   = ex_mem_q.dwen & ihit;

  always_comb begin
    mem_wb_d.wdata = ex_mem_q.dren ? dmemload : ex_mem_q.result;
    mem_wb_d.dest  = ex_mem_q.dest;
    mem_wb_d.wen   = ex_mem_q.wen;
    mem_wb_d.halt  = ex_mem_q.halt;
  end

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_inst (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .enable (ihit),
    .flush  (flush_mem_wb),
    .d      (mem_wb_d),
    .q      (mem_wb_q)
  );

endmodule

// File: verilog/forward_unit.sv
// operand forwarding selects for the EX stage
// EX/MEM result beats MEM/WB write data when both match
`timescale 1ns/1ps

module forward_unit (
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  cpu_types_pkg::regbits_t exmem_dest,
  input  cpu_types_pkg::regbits_t memwb_dest,
  input  logic                    exmem_wen,
  input  logic                    memwb_wen,
  output logic [1:0]              fwd_a,
  output logic [1:0]              fwd_b
);
  import cpu_types_pkg::*;

  logic exmem_live;
  logic memwb_live;

  // r0 never counts as a producer
  assign exmem_live = exmem_wen && (exmem_dest != '0);
  assign memwb_live = memwb_wen && (memwb_dest != '0);

  assign fwd_a = (exmem_live && (exmem_dest == rs)) ? FWD_EXMEM :
                 (memwb_live && (memwb_dest == rs)) ? FWD_MEMWB : FWD_IDEX;
  assign fwd_b = (exmem_live && (exmem_dest == rt)) ? FWD_EXMEM :
                 (memwb_live && (memwb_dest == rt)) ? FWD_MEMWB : FWD_IDEX;

endmodule

// File: verilog/pipe_reg.sv
// generic pipeline stage register
// enable holds the stage, flush inserts a bubble
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     enable,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload is a bubble, every strobe low
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (enable) begin
      if (flush) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

// File: verilog/register_file.sv
// 32 x 32-bit register file, r0 reads as zero
// same-cycle write data bypassed to both read ports
`timescale 1ns/1ps

module register_file (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  // entry zero keeps its reset value, writes to it are dropped
  word_t regs [32];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // zero check first, then bypass, then array
  assign rdat1 = (rsel1 == '0) ? '0 :
                 (wen && (wsel == rsel1)) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 :
                 (wen && (wsel == rsel2)) ? wdat : regs[rsel2];

endmodule
